//--- compile.f
+incdir+verilog
verilog/rhd_spi_pkg.sv
verilog/rhd_rec_pkg.sv
verilog/rhd_spi_master.sv
verilog/rhd_miso_lane.sv
verilog/rhd_record_seq.sv
verilog/rhd_recorder.sv
tests/tb_clk_gen.sv
tests/rhd_chip_model.sv
tests/tb_rhd_recorder.sv

//--- Bender.yml
package:
  name: rhd_recorder

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rhd_spi_pkg.sv
      - verilog/rhd_rec_pkg.sv
      - verilog/rhd_spi_master.sv
      - verilog/rhd_miso_lane.sv
      - verilog/rhd_record_seq.sv
      - verilog/rhd_recorder.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_clk_gen.sv
      - tests/rhd_chip_model.sv
      - tests/tb_rhd_recorder.sv

//--- tests/tb_rhd_recorder.sv
`timescale 1ns/1ns
`include "rhd_macros.svh"

module tb_rhd_recorder;
    import rhd_spi_pkg::*;
    import rhd_rec_pkg::*;

    localparam int RUNS = 3;
    // Each command also passes through load, tx and the done hand-off.
    localparam int CMD_CYCLES = `RHD_SPI_FRAME_CYCLES + 3;
    localparam int LIMIT = RUNS * `RHD_FRAME_CMDS * CMD_CYCLES + 200;

    logic                             clk;
    logic                             rstn;
    logic                             record_start;
    rhd_offset_t [`RHD_LANES-1:0]     oversample_offset;
    logic [`RHD_LANES-1:0]            miso;
    logic                             cs;
    logic                             sclk;
    logic                             mosi;
    logic                             busy;
    logic                             done;
    logic                             sample_valid;
    rhd_sample_t                      sample;
    rhd_lane_words_t [`RHD_LANES-1:0] chip_id;
    rhd_word_t                        rx_word;
    int                               rx_count;

    int   cycles = 0;
    int   seen_words = 0;
    int   cmd_count = 0;
    int   sample_count = 0;
    int   accepts = 0;
    int   dones = 0;
    logic accepted = 1'b0;
    logic exp_busy = 1'b0;
    logic prev_done = 1'b0;
    logic reset_seen = 1'b0;
    logic released = 1'b0;

    tb_clk_gen clk_gen_i (
        .clk  (clk),
        .rstn (rstn)
    );

    rhd_chip_model chip_i (
        .clk      (clk),
        .cs       (cs),
        .sclk     (sclk),
        .mosi     (mosi),
        .delay    (oversample_offset),
        .miso     (miso),
        .rx_word  (rx_word),
        .rx_count (rx_count)
    );

    rhd_recorder dut_i (
        .clk               (clk),
        .rstn              (rstn),
        .record_start      (record_start),
        .oversample_offset (oversample_offset),
        .miso              (miso),
        .cs                (cs),
        .sclk              (sclk),
        .mosi              (mosi),
        .busy              (busy),
        .done              (done),
        .sample_valid      (sample_valid),
        .sample            (sample),
        .chip_id           (chip_id)
    );

    function automatic rhd_word_t expected_cmd(int k);
        if (k < `RHD_CONVERTS) begin
            return {op_convert, 6'(k), 8'(`RHD_DSP_OFFSET_REMOVAL)};
        end
        return {op_read, 6'(`RHD_CHIP_ID_REG), 8'h00};
    endfunction

    task automatic fail_now(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles   <= cycles + 1;
        accepted <= rstn && record_start && !busy;
        if (!rstn) begin
            reset_seen <= 1'b1;
        end
        if (cycles == LIMIT) begin
            $display("Timeout: the runs did not finish within %0d clock cycles.", LIMIT);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (reset_seen && (!rstn || !released)) begin
            assert (cs === 1'b1 && sclk === 1'b0 && busy === 1'b0 && done === 1'b0 &&
                    sample_valid === 1'b0)
            else fail_now("outputs not idle during or right after reset");
        end
        if (reset_seen && rstn) begin
            released = 1'b1;
            if (prev_done) begin
                exp_busy = 1'b0;
            end
            if (accepted) begin
                cmd_count    = 0;
                sample_count = 0;
                exp_busy     = 1'b1;
                accepts      = accepts + 1;
            end
            assert (busy === exp_busy)
            else fail_now($sformatf("busy is %b, expected %b", busy, exp_busy));
            if (rx_count != seen_words) begin
                assert (rx_word === expected_cmd(cmd_count))
                else fail_now($sformatf("command %0d is %h, expected %h",
                                        cmd_count, rx_word, expected_cmd(cmd_count)));
                cmd_count  = cmd_count + 1;
                seen_words = rx_count;
            end
            if (sample_valid) begin
                assert (sample_count < `RHD_CONVERTS)
                else fail_now("more samples than channels in one run");
                assert (int'(sample.channel) == sample_count)
                else fail_now($sformatf("sample channel %0d, expected %0d",
                                        sample.channel, sample_count));
                for (int l = 0; l < `RHD_LANES; l++) begin
                    assert (sample.lanes[l].a === chip_i.convert_word(l, 0, sample_count))
                    else fail_now($sformatf("lane %0d side a of channel %0d is %h",
                                            l, sample_count, sample.lanes[l].a));
                    assert (sample.lanes[l].b === chip_i.convert_word(l, 1, sample_count))
                    else fail_now($sformatf("lane %0d side b of channel %0d is %h",
                                            l, sample_count, sample.lanes[l].b));
                end
                sample_count = sample_count + 1;
            end
            if (done) begin
                assert (!prev_done) else fail_now("done held for more than one cycle");
                assert (cmd_count == `RHD_FRAME_CMDS)
                else fail_now($sformatf("%0d commands in the run, expected %0d",
                                        cmd_count, `RHD_FRAME_CMDS));
                assert (sample_count == `RHD_CONVERTS)
                else fail_now($sformatf("%0d samples in the run, expected %0d",
                                        sample_count, `RHD_CONVERTS));
                for (int l = 0; l < `RHD_LANES; l++) begin
                    assert (chip_id[l].a === chip_i.chip_id_word(l, 0) &&
                            chip_id[l].b === chip_i.chip_id_word(l, 1))
                    else fail_now($sformatf("chip ID of lane %0d is %h/%h",
                                            l, chip_id[l].a, chip_id[l].b));
                end
                dones = dones + 1;
            end
            prev_done = done;
        end
    end

    initial begin
        int rnd;
        rnd               = $urandom(28229);
        record_start      = 1'b0;
        oversample_offset = '0;
        @(posedge rstn);
        for (int run = 0; run < RUNS; run++) begin
            @(negedge clk);
            for (int l = 0; l < `RHD_LANES; l++) begin
                oversample_offset[l] = rhd_offset_t'($urandom_range(0, `RHD_MAX_OFFSET));
            end
            repeat (2) @(negedge clk);
            record_start = 1'b1;
            @(negedge clk);
            record_start = 1'b0;
            // Extra request once half the channels are in.
            do @(posedge clk); while (sample_count < `RHD_CONVERTS / 2);
            @(negedge clk);
            record_start = 1'b1;
            @(negedge clk);
            record_start = 1'b0;
            do @(posedge clk); while (dones <= run);
            repeat (4) @(negedge clk);
        end
        if (accepts == RUNS && dones == RUNS) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_now($sformatf("%0d runs accepted and %0d done, expected %0d",
                               accepts, dones, RUNS));
        end
    end

endmodule

//--- tests/rhd_chip_model.sv
`timescale 1ns/1ns
`include "rhd_macros.svh"

module rhd_chip_model (
    input  logic                                      clk,
    input  logic                                      cs,
    input  logic                                      sclk,
    input  logic                                      mosi,
    input  rhd_spi_pkg::rhd_offset_t [`RHD_LANES-1:0] delay,
    output logic [`RHD_LANES-1:0]                     miso,
    output rhd_spi_pkg::rhd_word_t                    rx_word,
    output int                                        rx_count
);
    import rhd_spi_pkg::*;

    localparam int W = `RHD_WORD_BITS;

    rhd_word_t                  shift_in;
    rhd_cmd_t                   hist [2];
    rhd_word_t                  resp_a [`RHD_LANES];
    rhd_word_t                  resp_b [`RHD_LANES];
    int                         rises;
    int                         falls;
    logic [`RHD_LANES-1:0]      raw;
    logic [`RHD_MAX_OFFSET-1:0] delay_line [`RHD_LANES];

    // Amplifier word for one channel, lane and side.
    function automatic rhd_word_t convert_word(int lane, int side, int channel);
        return {2'(lane), 1'(side), 5'(channel), ~5'(channel), 3'(lane + side + 1)};
    endfunction

    function automatic rhd_word_t chip_id_word(int lane, int side);
        return {8'(side + 1), 4'(lane), 4'h1};
    endfunction

    function automatic rhd_word_t response_word(rhd_cmd_t c, int lane, int side);
        if (c.op == op_convert) begin
            return convert_word(lane, side, int'(c.addr));
        end else if (c.op == op_read && c.addr == 6'(`RHD_CHIP_ID_REG)) begin
            return chip_id_word(lane, side);
        end
        return '0;
    endfunction

    initial begin
        shift_in = '0;
        rx_word  = '0;
        rx_count = 0;
        rises    = 0;
        falls    = 0;
        hist[0]  = '0;
        hist[1]  = '0;
        for (int l = 0; l < `RHD_LANES; l++) begin
            resp_a[l]     = '0;
            resp_b[l]     = '0;
            delay_line[l] = '0;
        end
    end

    // Answer the command sent two frames earlier.
    always @(negedge cs) begin
        rises = 0;
        falls = 0;
        for (int l = 0; l < `RHD_LANES; l++) begin
            resp_a[l] = response_word(hist[1], l, 0);
            resp_b[l] = response_word(hist[1], l, 1);
        end
    end

    always @(posedge sclk) begin
        if (cs === 1'b0) begin
            shift_in = {shift_in[W-2:0], mosi};
            rises    = rises + 1;
            if (rises == W) begin
                rx_word  = shift_in;
                rx_count = rx_count + 1;
                hist[1]  = hist[0];
                hist[0]  = shift_in;
            end
        end
    end

    always @(negedge sclk) begin
        if (cs === 1'b0) begin
            falls = falls + 1;
        end
    end

    // Side a while SCLK is high, side b while low.
    always_comb begin
        for (int l = 0; l < `RHD_LANES; l++) begin
            if (sclk && rises > 0) begin
                raw[l] = resp_a[l][W - rises];
            end else if (!sclk && falls > 0) begin
                raw[l] = resp_b[l][W - falls];
            end else begin
                raw[l] = 1'b0;
            end
        end
    end

    // Cable delay in clock cycles.
    always @(posedge clk) begin
        for (int l = 0; l < `RHD_LANES; l++) begin
            delay_line[l] <= {delay_line[l][`RHD_MAX_OFFSET-2:0], raw[l]};
        end
    end

    always_comb begin
        for (int l = 0; l < `RHD_LANES; l++) begin
            if (delay[l] == '0) begin
                miso[l] = raw[l];
            end else begin
                miso[l] = delay_line[l][delay[l] - 1];
            end
        end
    end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release on a falling edge like the rest of the stimulus.
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

//--- verilog/rhd_recorder.sv
`timescale 1ns/1ns
`include "rhd_macros.svh"

module rhd_recorder (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic                                          record_start,
    input  rhd_spi_pkg::rhd_offset_t [`RHD_LANES-1:0]     oversample_offset,
    input  logic [`RHD_LANES-1:0]                         miso,
    output logic                                          cs,
    output logic                                          sclk,
    output logic                                          mosi,
    output logic                                          busy,
    output logic                                          done,
    output logic                                          sample_valid,
    output rhd_rec_pkg::rhd_sample_t                      sample,
    output rhd_rec_pkg::rhd_lane_words_t [`RHD_LANES-1:0] chip_id
);
    import rhd_spi_pkg::*;
    import rhd_rec_pkg::*;

    rhd_cmd_t                         cmd;
    spi_tick_t                        tick;
    logic                             spi_start;
    logic                             spi_done;
    rhd_lane_words_t [`RHD_LANES-1:0] lane_words;

    rhd_spi_master u_master (
        .clk   (clk),
        .rstn  (rstn),
        .start (spi_start),
        .cmd   (cmd),
        .cs    (cs),
        .sclk  (sclk),
        .mosi  (mosi),
        .tick  (tick),
        .done  (spi_done)
    );

    // One deserializer per MISO line, each with its own delay.
    for (genvar i = 0; i < `RHD_LANES; i++) begin : g_lane
        rhd_miso_lane u_lane (
            .clk    (clk),
            .rstn   (rstn),
            .tick   (tick),
            .offset (oversample_offset[i]),
            .miso   (miso[i]),
            .words  (lane_words[i])
        );
    end

    rhd_record_seq u_seq (
        .clk          (clk),
        .rstn         (rstn),
        .record_start (record_start),
        .spi_done     (spi_done),
        .lane_words   (lane_words),
        .spi_start    (spi_start),
        .cmd          (cmd),
        .busy         (busy),
        .done         (done),
        .sample_valid (sample_valid),
        .sample       (sample),
        .chip_id      (chip_id)
    );

endmodule

//--- verilog/rhd_record_seq.sv
`timescale 1ns/1ns
`include "rhd_macros.svh"

module rhd_record_seq (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic                                          record_start,
    input  logic                                          spi_done,
    input  rhd_rec_pkg::rhd_lane_words_t [`RHD_LANES-1:0] lane_words,
    output logic                                          spi_start,
    output rhd_spi_pkg::rhd_cmd_t                         cmd,
    output logic                                          busy,
    output logic                                          done,
    output logic                                          sample_valid,
    output rhd_rec_pkg::rhd_sample_t                      sample,
    output rhd_rec_pkg::rhd_lane_words_t [`RHD_LANES-1:0] chip_id
);
    import rhd_spi_pkg::*;
    import rhd_rec_pkg::*;

    localparam int IDX_W = $clog2(`RHD_FRAME_CMDS);
    localparam int CH_W  = $clog2(`RHD_CONVERTS);

    rec_state_e       state;
    logic [IDX_W-1:0] cmd_idx;
    logic             in_window;
    logic             id_slot;
    logic             last_cmd;
    rhd_cmd_t         next_cmd;

    assign busy = (state != rec_ready);
    assign done = (state == rec_done);

    // Results lag their command by the pipe delay.
    assign in_window = (cmd_idx >= IDX_W'(`RHD_PIPE_DELAY)) &&
                       (cmd_idx < IDX_W'(`RHD_CONVERTS + `RHD_PIPE_DELAY));
    assign id_slot   = (cmd_idx == IDX_W'(`RHD_CONVERTS + `RHD_PIPE_DELAY));
    assign last_cmd  = (cmd_idx == IDX_W'(`RHD_FRAME_CMDS - 1));

    always_comb begin
        if (cmd_idx < IDX_W'(`RHD_CONVERTS)) begin
            next_cmd.op   = op_convert;
            next_cmd.addr = 6'(cmd_idx);
            next_cmd.data = 8'(`RHD_DSP_OFFSET_REMOVAL);
        end else begin
            next_cmd.op   = op_read;
            next_cmd.addr = 6'(`RHD_CHIP_ID_REG);
            next_cmd.data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= rec_ready;
            cmd_idx      <= '0;
            spi_start    <= 1'b0;
            sample_valid <= 1'b0;
            chip_id      <= '0;
        end else begin
            spi_start    <= 1'b0;
            sample_valid <= 1'b0;
            case (state)
                rec_ready: begin
                    if (record_start) begin
                        cmd_idx <= '0;
                        state   <= rec_load;
                    end
                end
                rec_load: begin
                    state <= rec_tx;
                end
                rec_tx: begin
                    spi_start <= 1'b1;
                    state     <= rec_rx;
                end
                rec_rx: begin
                    if (spi_done) begin
                        if (in_window) begin
                            sample_valid <= 1'b1;
                        end
                        if (id_slot) begin
                            chip_id <= lane_words;
                        end
                        if (last_cmd) begin
                            state <= rec_done;
                        end else begin
                            cmd_idx <= cmd_idx + 1'b1;
                            state   <= rec_load;
                        end
                    end
                end
                rec_done: begin
                    state <= rec_ready;
                end
                default: begin
                    state <= rec_ready;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rec_load) begin
            cmd <= next_cmd;
        end
        if (state == rec_rx && spi_done && in_window) begin
            sample.channel <= CH_W'(cmd_idx - IDX_W'(`RHD_PIPE_DELAY));
            sample.lanes   <= lane_words;
        end
    end

endmodule

//--- verilog/rhd_miso_lane.sv
`timescale 1ns/1ns
`include "rhd_macros.svh"

module rhd_miso_lane (
    input  logic                          clk,
    input  logic                          rstn,
    input  rhd_spi_pkg::spi_tick_t        tick,
    input  rhd_spi_pkg::rhd_offset_t      offset,
    input  logic                          miso,
    output rhd_rec_pkg::rhd_lane_words_t  words
);
    import rhd_spi_pkg::*;

    localparam int W     = `RHD_WORD_BITS;
    localparam int CNT_W = $clog2(`RHD_WORD_BITS);

    // Entry i holds the tick delayed by i+1 cycles.
    spi_tick_t [`RHD_MAX_OFFSET-1:0] tick_line;
    spi_tick_t                       tick_d;
    logic [CNT_W-1:0]                rise_cnt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tick_line <= '0;
        end else begin
            tick_line <= {tick_line[`RHD_MAX_OFFSET-2:0], tick};
        end
    end

    always_comb begin
        if (offset == '0) begin
            tick_d = tick;
        end else begin
            tick_d = tick_line[offset - 1'b1];
        end
    end

    // Counts rises within a word, wraps at the frame end.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rise_cnt <= '0;
        end else if (tick_d.rise) begin
            rise_cnt <= rise_cnt + 1'b1;
        end
    end

    // Side a after rising SCLK, side b after falling.
    always_ff @(posedge clk) begin
        if (tick_d.rise) begin
            if (rise_cnt == '0) begin
                words.a <= {{(W - 1){1'b0}}, miso};
                words.b <= '0;
            end else begin
                words.a <= {words.a[W-2:0], miso};
            end
        end
        if (tick_d.fall) begin
            words.b <= {words.b[W-2:0], miso};
        end
    end

endmodule

//--- verilog/rhd_spi_master.sv
`timescale 1ns/1ns
`include "rhd_macros.svh"

module rhd_spi_master (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    input  rhd_spi_pkg::rhd_cmd_t   cmd,
    output logic                    cs,
    output logic                    sclk,
    output logic                    mosi,
    output rhd_spi_pkg::spi_tick_t  tick,
    output logic                    done
);
    import rhd_spi_pkg::*;

    localparam int DIV_W   = $clog2(`RHD_SCLK_DIV);
    localparam int BIT_W   = $clog2(`RHD_WORD_BITS);
    localparam int GUARD_W = $clog2(`RHD_MAX_OFFSET + 2);
    localparam int HALF    = `RHD_SCLK_DIV / 2;

    logic               shifting;
    logic               tail;
    logic               guarding;
    logic               idle;
    logic               rise_edge;
    logic               fall_edge;
    logic [DIV_W-1:0]   div_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    logic [GUARD_W-1:0] guard_cnt;
    rhd_word_t          shreg;

    assign idle      = !(shifting || tail || guarding);
    assign rise_edge = shifting && (div_cnt == DIV_W'(HALF - 1));
    assign fall_edge = shifting && (div_cnt == DIV_W'(`RHD_SCLK_DIV - 1));
    assign mosi      = shreg[`RHD_WORD_BITS-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cs        <= 1'b1;
            sclk      <= 1'b0;
            tick      <= '0;
            done      <= 1'b0;
            shifting  <= 1'b0;
            tail      <= 1'b0;
            guarding  <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            guard_cnt <= '0;
            shreg     <= '0;
        end else begin
            tick <= '0;
            done <= 1'b0;
            if (shifting || tail) begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (start && idle) begin
                cs       <= 1'b0;
                shifting <= 1'b1;
                div_cnt  <= '0;
                bit_cnt  <= '0;
                shreg    <= cmd;
            end
            if (rise_edge) begin
                sclk      <= 1'b1;
                tick.rise <= 1'b1;
            end
            // MOSI moves on the falling edge.
            if (fall_edge) begin
                sclk      <= 1'b0;
                tick.fall <= 1'b1;
                bit_cnt   <= bit_cnt + 1'b1;
                shreg     <= {shreg[`RHD_WORD_BITS-2:0], 1'b0};
                if (bit_cnt == BIT_W'(`RHD_WORD_BITS - 1)) begin
                    shifting <= 1'b0;
                    tail     <= 1'b1;
                end
            end
            // Half a period low before CS releases.
            if (tail && div_cnt == DIV_W'(HALF - 1)) begin
                tail      <= 1'b0;
                cs        <= 1'b1;
                guarding  <= 1'b1;
                guard_cnt <= '0;
            end
            // Wait out the largest lane delay.
            if (guarding) begin
                guard_cnt <= guard_cnt + 1'b1;
                if (guard_cnt == GUARD_W'(`RHD_MAX_OFFSET + 1)) begin
                    guarding <= 1'b0;
                    done     <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/rhd_rec_pkg.sv
`include "rhd_macros.svh"

package rhd_rec_pkg;

    // Both chips sharing one MISO line.
    typedef struct packed {
        rhd_spi_pkg::rhd_word_t a;
        rhd_spi_pkg::rhd_word_t b;
    } rhd_lane_words_t;

    // Lane 0 sits in the low bits.
    typedef struct packed {
        logic [$clog2(`RHD_CONVERTS)-1:0]   channel;
        rhd_lane_words_t [`RHD_LANES-1:0]   lanes;
    } rhd_sample_t;

    typedef enum logic [2:0] {
        rec_ready,
        rec_load,
        rec_tx,
        rec_rx,
        rec_done
    } rec_state_e;

endpackage

//--- verilog/rhd_spi_pkg.sv
`include "rhd_macros.svh"

package rhd_spi_pkg;

    typedef logic [`RHD_WORD_BITS-1:0] rhd_word_t;

    typedef enum logic [1:0] {
        op_convert = 2'b00,
        op_write   = 2'b10,
        op_read    = 2'b11
    } rhd_op_e;

    // Command word as sent MSB first.
    typedef struct packed {
        rhd_op_e    op;
        logic [5:0] addr;
        logic [7:0] data;
    } rhd_cmd_t;

    typedef logic [$clog2(`RHD_MAX_OFFSET + 1)-1:0] rhd_offset_t;

    // One-cycle pulses at the SCLK edges.
    typedef struct packed {
        logic rise;
        logic fall;
    } spi_tick_t;

endpackage

//--- verilog/rhd_macros.svh
`ifndef RHD_MACROS_SVH
`define RHD_MACROS_SVH

// Lanes and frame layout.
`define RHD_LANES 2
`define RHD_CONVERTS 32
`define RHD_FRAME_CMDS 35
`define RHD_PIPE_DELAY 2

// SPI word and clocking.
`define RHD_WORD_BITS 16
`define RHD_SCLK_DIV 4
`define RHD_MAX_OFFSET 15

// Start pulse to done pulse of one transfer.
`define RHD_SPI_FRAME_CYCLES \
    ((`RHD_WORD_BITS * `RHD_SCLK_DIV) + (`RHD_SCLK_DIV / 2) + `RHD_MAX_OFFSET + 3)

`define RHD_CHIP_ID_REG 63
`define RHD_DSP_OFFSET_REMOVAL 1

`endif
